//--- bench/tb_wb_subsys.sv
`include "wb_xbar_defines.svh"

`timescale 1ns/1ps
`default_nettype none

module tb_wb_subsys;

	localparam int CLK_PERIOD = 4;

	logic              clk;
	logic              rstn;
	logic              m0_cyc;
	logic              m0_stb;
	logic              m0_we;
	wb_xbar_pkg::adr_t m0_adr;
	wb_xbar_pkg::dat_t m0_dat;
	wb_xbar_pkg::sel_t m0_sel;
	wb_xbar_pkg::dat_t m0_dat_r;
	logic              m0_ack;
	logic              m0_err;
	logic              m1_cyc;
	logic              m1_stb;
	logic              m1_we;
	wb_xbar_pkg::adr_t m1_adr;
	wb_xbar_pkg::dat_t m1_dat;
	wb_xbar_pkg::sel_t m1_sel;
	wb_xbar_pkg::dat_t m1_dat_r;
	logic              m1_ack;
	logic              m1_err;
	logic              cfg_we;
	logic              cfg_sel;
	wb_xbar_pkg::adr_t cfg_data;

	// Shadow of the SRAM and of the last grant per target, 0 is SRAM and 1 decode-fail
	wb_xbar_pkg::dat_t model [2**`WB_MEM_AW];
	logic              last_gnt [2];

	integer            seed = 32'h5149_95dc;
	int                fd;
	int                rc;
	int                n_lines;
	int                budget_cycles = 0;
	int                op_no;
	int                cycle_cnt = 0;
	reg [8*8-1:0]      tok;
	reg [8*256-1:0]    line;
	string             name;

	// Fields of the first and second access on a line
	int                m_a;
	int                w_a;
	int                e_a;
	int                m_b;
	int                w_b;
	int                e_b;
	wb_xbar_pkg::adr_t a_a;
	wb_xbar_pkg::adr_t a_b;
	wb_xbar_pkg::dat_t d_a;
	wb_xbar_pkg::dat_t d_b;
	wb_xbar_pkg::dat_t x_a;
	wb_xbar_pkg::dat_t x_b;
	wb_xbar_pkg::sel_t s_a;
	wb_xbar_pkg::sel_t s_b;
	wb_xbar_pkg::dat_t rd0;
	wb_xbar_pkg::dat_t rd1;
	logic              e0;
	logic              e1;
	int                c0;
	int                c1;
	logic              winner;

	wb_subsys_top i_wb_subsys_top (
		.clk        (clk),
		.rstn       (rstn),
		.m0_cyc_i   (m0_cyc),
		.m0_stb_i   (m0_stb),
		.m0_we_i    (m0_we),
		.m0_adr_i   (m0_adr),
		.m0_dat_i   (m0_dat),
		.m0_sel_i   (m0_sel),
		.m0_dat_o   (m0_dat_r),
		.m0_ack_o   (m0_ack),
		.m0_err_o   (m0_err),
		.m1_cyc_i   (m1_cyc),
		.m1_stb_i   (m1_stb),
		.m1_we_i    (m1_we),
		.m1_adr_i   (m1_adr),
		.m1_dat_i   (m1_dat),
		.m1_sel_i   (m1_sel),
		.m1_dat_o   (m1_dat_r),
		.m1_ack_o   (m1_ack),
		.m1_err_o   (m1_err),
		.cfg_we_i   (cfg_we),
		.cfg_sel_i  (cfg_sel),
		.cfg_data_i (cfg_data)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
	end

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("Simulation FAILED");
		$fatal(1);
	endtask

	task automatic check_value(input string what, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			abort_run($sformatf("MISMATCH %s expected %h actual %h", what, expected, actual));
		end
	endtask

	// Classic cycle on master 0, held until ack or err
	task automatic drive_master0(input logic we, input wb_xbar_pkg::adr_t adr,
			input wb_xbar_pkg::dat_t dat, input wb_xbar_pkg::sel_t sel,
			output wb_xbar_pkg::dat_t rd, output logic got_err, output int resp_cycle);
		@(posedge clk);
		#1;
		m0_cyc = 1'b1;
		m0_stb = 1'b1;
		m0_we  = we;
		m0_adr = adr;
		m0_dat = dat;
		m0_sel = sel;
		do begin
			@(posedge clk);
			#1;
		end while (!(m0_ack || m0_err));
		check_value("m0 one of ack and err", 1, m0_ack ^ m0_err);
		rd         = m0_dat_r;
		got_err    = m0_err;
		resp_cycle = cycle_cnt;
		@(posedge clk);
		#1;
		check_value("m0 response is one cycle", 0, m0_ack | m0_err);
		m0_cyc = 1'b0;
		m0_stb = 1'b0;
		m0_we  = 1'b0;
	endtask

	task automatic drive_master1(input logic we, input wb_xbar_pkg::adr_t adr,
			input wb_xbar_pkg::dat_t dat, input wb_xbar_pkg::sel_t sel,
			output wb_xbar_pkg::dat_t rd, output logic got_err, output int resp_cycle);
		@(posedge clk);
		#1;
		m1_cyc = 1'b1;
		m1_stb = 1'b1;
		m1_we  = we;
		m1_adr = adr;
		m1_dat = dat;
		m1_sel = sel;
		do begin
			@(posedge clk);
			#1;
		end while (!(m1_ack || m1_err));
		check_value("m1 one of ack and err", 1, m1_ack ^ m1_err);
		rd         = m1_dat_r;
		got_err    = m1_err;
		resp_cycle = cycle_cnt;
		@(posedge clk);
		#1;
		check_value("m1 response is one cycle", 0, m1_ack | m1_err);
		m1_cyc = 1'b0;
		m1_stb = 1'b0;
		m1_we  = 1'b0;
	endtask

	task automatic run_access(input int m, input logic we, input wb_xbar_pkg::adr_t adr,
			input wb_xbar_pkg::dat_t dat, input wb_xbar_pkg::sel_t sel,
			output wb_xbar_pkg::dat_t rd, output logic got_err, output int resp_cycle);
		if (m == 0) begin
			drive_master0(we, adr, dat, sel, rd, got_err, resp_cycle);
		end else begin
			drive_master1(we, adr, dat, sel, rd, got_err, resp_cycle);
		end
	endtask

	task automatic write_window(input logic sel, input wb_xbar_pkg::adr_t value);
		@(posedge clk);
		#1;
		cfg_we   = 1'b1;
		cfg_sel  = sel;
		cfg_data = value;
		@(posedge clk);
		#1;
		cfg_we = 1'b0;
	endtask

	// Byte lanes with sel set take the new data
	task automatic merge_write(input wb_xbar_pkg::adr_t adr, input wb_xbar_pkg::dat_t dat,
			input wb_xbar_pkg::sel_t sel);
		logic [`WB_MEM_AW-1:0] idx;
		idx = adr[`WB_MEM_AW+1:2];
		for (int b = 0; b < `WB_SEL_W; b++) begin
			if (sel[b]) begin
				model[idx][8*b +: 8] = dat[8*b +: 8];
			end
		end
	endtask

	task automatic check_access(input string what, input int we, input wb_xbar_pkg::adr_t adr,
			input wb_xbar_pkg::dat_t dat, input wb_xbar_pkg::sel_t sel,
			input wb_xbar_pkg::dat_t exp_dat, input int exp_err,
			input wb_xbar_pkg::dat_t rd, input logic got_err);
		check_value({what, " err"}, exp_err, got_err);
		if (we == 0 || exp_err != 0) begin
			check_value({what, " data"}, exp_dat, rd);
		end
		if (we == 0 && exp_err == 0) begin
			check_value({what, " model"}, model[adr[`WB_MEM_AW+1:2]], rd);
		end
		if (we != 0 && exp_err == 0) begin
			merge_write(adr, dat, sel);
		end
	endtask

	// Random words from one master, read back by the other
	task automatic fill_and_verify(input string what, input int m,
			input wb_xbar_pkg::adr_t base, input int count);
		wb_xbar_pkg::adr_t a;
		wb_xbar_pkg::dat_t wd;
		wb_xbar_pkg::dat_t rd;
		logic              got_err;
		int                resp;
		for (int i = 0; i < count; i++) begin
			a  = base + 4 * i;
			wd = $random(seed);
			run_access(m, 1'b1, a, wd, 4'hf, rd, got_err, resp);
			check_value($sformatf("%s fill %0d err", what, i), 0, got_err);
			merge_write(a, wd, 4'hf);
		end
		for (int i = 0; i < count; i++) begin
			a = base + 4 * i;
			run_access(1 - m, 1'b0, a, '0, 4'hf, rd, got_err, resp);
			check_value($sformatf("%s read %0d err", what, i), 0, got_err);
			check_value($sformatf("%s read %0d data", what, i), model[a[`WB_MEM_AW+1:2]], rd);
		end
		last_gnt[0] = (m == 0);
	endtask

	initial begin : watchdog
		wait (budget_cycles != 0);
		#(budget_cycles * CLK_PERIOD);
		abort_run("Run timed out before the stimulus file was finished");
	end

	initial begin
		rstn     = 1'b0;
		m0_cyc   = 1'b0;
		m0_stb   = 1'b0;
		m0_we    = 1'b0;
		m0_adr   = '0;
		m0_dat   = '0;
		m0_sel   = '0;
		m1_cyc   = 1'b0;
		m1_stb   = 1'b0;
		m1_we    = 1'b0;
		m1_adr   = '0;
		m1_dat   = '0;
		m1_sel   = '0;
		cfg_we   = 1'b0;
		cfg_sel  = 1'b0;
		cfg_data = '0;
		for (int i = 0; i < 2**`WB_MEM_AW; i++) begin
			model[i] = '0;
		end
		// Master 1 counts as the last winner after reset
		last_gnt[0] = 1'b1;
		last_gnt[1] = 1'b1;
		op_no       = 0;

		fd = $fopen("bench/wb_stimulus.txt", "r");
		if (fd == 0) begin
			abort_run("Cannot open the stimulus file bench/wb_stimulus.txt");
		end
		n_lines = 0;
		while (!$feof(fd)) begin
			if ($fgets(line, fd) > 0) begin
				n_lines++;
			end
		end
		$fclose(fd);
		if (n_lines == 0) begin
			abort_run("The stimulus file is empty");
		end
		budget_cycles = n_lines * 40;
		fd = $fopen("bench/wb_stimulus.txt", "r");

		repeat (3) @(posedge clk);
		#1;
		rstn = 1'b1;

		while ($fscanf(fd, "%s", tok) == 1) begin
			if (tok == "#") begin
				rc = $fgets(line, fd);
			end else begin
				op_no++;
				name = $sformatf("op %0d", op_no);
				rc = $fscanf(fd, "%d %d %h %h %h %h %d", m_a, w_a, a_a, d_a, s_a, x_a, e_a);
				if (rc != 7) begin
					abort_run($sformatf("Stimulus %s has missing or malformed fields", name));
				end
				if (tok == "S") begin
					run_access(m_a, w_a[0], a_a, d_a, s_a, rd0, e0, c0);
					check_access(name, w_a, a_a, d_a, s_a, x_a, e_a, rd0, e0);
					last_gnt[e_a] = m_a[0];
				end else if (tok == "P") begin
					rc = $fscanf(fd, "%d %d %h %h %h %h %d", m_b, w_b, a_b, d_b, s_b, x_b, e_b);
					if (rc != 7) begin
						abort_run($sformatf("Stimulus %s lacks the second master's fields", name));
					end
					fork
						drive_master0(w_a[0], a_a, d_a, s_a, rd0, e0, c0);
						drive_master1(w_b[0], a_b, d_b, s_b, rd1, e1, c1);
					join
					check_access({name, " m0"}, w_a, a_a, d_a, s_a, x_a, e_a, rd0, e0);
					check_access({name, " m1"}, w_b, a_b, d_b, s_b, x_b, e_b, rd1, e1);
					if (e_a == e_b) begin
						// Tie on one target goes to the master not granted last
						winner = !last_gnt[e_a];
						check_value({name, " serialized"}, 1, c0 != c1);
						check_value({name, " tie winner"}, winner, c1 < c0);
						last_gnt[e_a] = !winner;
					end else begin
						last_gnt[e_a] = 1'b0;
						last_gnt[e_b] = 1'b1;
					end
				end else if (tok == "C") begin
					write_window(m_a[0], d_a);
				end else if (tok == "R") begin
					fill_and_verify(name, m_a, a_a, d_a);
				end else begin
					abort_run($sformatf("Stimulus %s has an unknown operation code", name));
				end
			end
		end
		$fclose(fd);

		$display("Simulation PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- bench/wb_stimulus.txt
# op master we adr data sel exp_dat exp_err, P repeats master..exp_err for master 1
# S single, P paired, C window write (master 0 base 1 limit, data value), R random fill (data count)
S 0 1 00001000 11223344 f 00000000 0
S 1 0 00001000 00000000 f 11223344 0
S 1 1 00001004 a5a5a5a5 f 00000000 0
S 0 0 00001004 00000000 f a5a5a5a5 0
S 0 1 00001004 0000cc00 2 00000000 0
S 1 0 00001004 00000000 f a5a5cca5 0
S 1 1 00001000 ee00ff00 9 00000000 0
S 0 0 00001000 00000000 f ee223300 0
S 0 1 00002000 deadbeef f 00000000 1
S 1 0 00000ffc 00000000 f 00000000 1
S 0 0 00001100 00000000 f 00000000 1
S 1 0 00001000 00000000 f ee223300 0
R 0 1 00001040 00000008 f 00000000 0
P 0 1 00001008 01020304 f 00000000 0 1 1 0000100c 05060708 f 00000000 0
P 0 0 0000100c 00000000 f 05060708 0 1 0 00001008 00000000 f 01020304 0
S 0 0 00001008 00000000 f 01020304 0
P 0 1 00001010 aaaa0000 c 00000000 0 1 1 00001014 0000bbbb 3 00000000 0
P 0 1 00001018 000000aa 1 00000000 0 1 1 00001018 0000bb00 2 00000000 0
S 1 0 00001018 00000000 f 0000bbaa 0
P 0 0 00001010 00000000 f aaaa0000 0 1 1 00003000 12345678 f 00000000 1
P 0 1 00000000 87654321 f 00000000 1 1 0 00001014 00000000 f 0000bbbb 0
P 0 0 00004000 00000000 f 00000000 1 1 0 00005000 00000000 f 00000000 1
S 0 0 00001000 00000000 f ee223300 0
C 0 0 00000000 00002000 0 00000000 0
C 1 0 00000000 000020ff 0 00000000 0
S 0 0 00001000 00000000 f 00000000 1
S 1 0 00002000 00000000 f ee223300 0
S 1 1 00002044 cafef00d f 00000000 0
S 0 0 00002044 00000000 f cafef00d 0
S 1 0 00001044 00000000 f 00000000 1
R 1 1 00002080 00000004 f 00000000 0

//--- sources.f
+incdir+verilog
verilog/wb_xbar_pkg.sv
verilog/wb_bus_if.sv
verilog/wb_rr_arbiter.sv
verilog/wb_window_regs.sv
verilog/wb_decode_err.sv
verilog/wb_sram_target.sv
verilog/wb_interconnect_2x1.sv
verilog/wb_subsys_top.sv
bench/tb_wb_subsys.sv

//--- verilog/wb_bus_if.sv
`timescale 1ns/1ps
`default_nettype none

interface wb_bus_if;

	// Request fields, driven by the initiator
	logic                    cyc;
	logic                    stb;
	logic                    we;
	wb_xbar_pkg::adr_t       adr;
	wb_xbar_pkg::dat_t       dat_w;
	wb_xbar_pkg::sel_t       sel;

	// Response fields, driven by the target
	wb_xbar_pkg::dat_t       dat_r;
	logic                    ack;
	logic                    err;

	modport initiator (
		output cyc,
		output stb,
		output we,
		output adr,
		output dat_w,
		output sel,
		input  dat_r,
		input  ack,
		input  err
	);

	modport target (
		input  cyc,
		input  stb,
		input  we,
		input  adr,
		input  dat_w,
		input  sel,
		output dat_r,
		output ack,
		output err
	);

endinterface

`default_nettype wire

//--- verilog/wb_decode_err.sv
`timescale 1ns/1ps
`default_nettype none

module wb_decode_err (
	input  logic     clk,
	input  logic     rstn,
	wb_bus_if.target bus
);

	logic err_q;

	// One err pulse per strobed cycle, never twice in a row
	always_ff @(posedge clk) begin
		if (!rstn) begin
			err_q <= 1'b0;
		end else begin
			err_q <= bus.cyc && bus.stb && !err_q;
		end
	end

	// No storage behind this target
	assign bus.err   = err_q;
	assign bus.ack   = 1'b0;
	assign bus.dat_r = wb_xbar_pkg::dat_t'(0);

endmodule

`default_nettype wire

//--- verilog/wb_interconnect_2x1.sv
`timescale 1ns/1ps
`default_nettype none

module wb_interconnect_2x1 (
	input  logic              clk,
	input  logic              rstn,
	input  wb_xbar_pkg::adr_t win_base_i,
	input  wb_xbar_pkg::adr_t win_limit_i,
	wb_bus_if.target          m0,
	wb_bus_if.target          m1,
	wb_bus_if.initiator       mem,
	wb_bus_if.initiator       err
);

	// Master side, index is the master number
	logic                    m_cyc   [2];
	logic                    m_stb   [2];
	logic                    m_we    [2];
	wb_xbar_pkg::adr_t       m_adr   [2];
	wb_xbar_pkg::dat_t       m_dat_w [2];
	wb_xbar_pkg::sel_t       m_sel   [2];
	wb_xbar_pkg::dat_t       m_dat_r [2];
	logic                    m_ack   [2];
	logic                    m_err   [2];

	// Target side, 0 is the SRAM and 1 the decode-fail target
	logic                    t_cyc   [2];
	logic                    t_stb   [2];
	logic                    t_we    [2];
	wb_xbar_pkg::adr_t       t_adr   [2];
	wb_xbar_pkg::dat_t       t_dat_w [2];
	wb_xbar_pkg::sel_t       t_sel   [2];
	wb_xbar_pkg::dat_t       t_dat_r [2];
	logic                    t_ack   [2];
	logic                    t_err   [2];

	wb_xbar_pkg::target_id_t pend    [2];
	logic [1:0]              t_req   [2];
	logic                    t_gnt   [2];
	wb_xbar_pkg::master_id_t t_gnt_id [2];

	assign m_cyc[0]   = m0.cyc;
	assign m_stb[0]   = m0.stb;
	assign m_we[0]    = m0.we;
	assign m_adr[0]   = m0.adr;
	assign m_dat_w[0] = m0.dat_w;
	assign m_sel[0]   = m0.sel;
	assign m0.dat_r   = m_dat_r[0];
	assign m0.ack     = m_ack[0];
	assign m0.err     = m_err[0];

	assign m_cyc[1]   = m1.cyc;
	assign m_stb[1]   = m1.stb;
	assign m_we[1]    = m1.we;
	assign m_adr[1]   = m1.adr;
	assign m_dat_w[1] = m1.dat_w;
	assign m_sel[1]   = m1.sel;
	assign m1.dat_r   = m_dat_r[1];
	assign m1.ack     = m_ack[1];
	assign m1.err     = m_err[1];

	assign mem.cyc    = t_cyc[0];
	assign mem.stb    = t_stb[0];
	assign mem.we     = t_we[0];
	assign mem.adr    = t_adr[0];
	assign mem.dat_w  = t_dat_w[0];
	assign mem.sel    = t_sel[0];
	assign t_dat_r[0] = mem.dat_r;
	assign t_ack[0]   = mem.ack;
	assign t_err[0]   = mem.err;

	assign err.cyc    = t_cyc[1];
	assign err.stb    = t_stb[1];
	assign err.we     = t_we[1];
	assign err.adr    = t_adr[1];
	assign err.dat_w  = t_dat_w[1];
	assign err.sel    = t_sel[1];
	assign t_dat_r[1] = err.dat_r;
	assign t_ack[1]   = err.ack;
	assign t_err[1]   = err.err;

	for (genvar k = 0; k < 2; k++) begin : g_master
		logic in_win;
		logic pend_err;
		logic routed;

		assign in_win = (m_adr[k] >= win_base_i) && (m_adr[k] <= win_limit_i);

		// Target is fixed at capture and kept until the answer
		always_ff @(posedge clk) begin
			if (!rstn) begin
				pend[k] <= wb_xbar_pkg::TGT_NONE;
			end else if (pend[k] != wb_xbar_pkg::TGT_NONE) begin
				if (m_ack[k] || m_err[k]) begin
					pend[k] <= wb_xbar_pkg::TGT_NONE;
				end
			end else if (m_cyc[k] && m_stb[k]) begin
				pend[k] <= in_win ? wb_xbar_pkg::TGT_MEM : wb_xbar_pkg::TGT_ERR;
			end
		end

		assign t_req[0][k] = (pend[k] == wb_xbar_pkg::TGT_MEM);
		assign t_req[1][k] = (pend[k] == wb_xbar_pkg::TGT_ERR);

		// Response only from the pending target, and only under its grant
		assign pend_err = (pend[k] == wb_xbar_pkg::TGT_ERR);
		assign routed   = (pend[k] != wb_xbar_pkg::TGT_NONE) && t_gnt[pend_err] &&
			(t_gnt_id[pend_err] == 1'(k));

		assign m_ack[k]   = routed && t_ack[pend_err];
		assign m_err[k]   = routed && t_err[pend_err];
		assign m_dat_r[k] = routed ? t_dat_r[pend_err] : '0;

		a_one_resp: assert property (
			@(posedge clk) disable iff (!rstn)
			!(m_ack[k] && m_err[k])
		);
	end

	for (genvar t = 0; t < 2; t++) begin : g_target
		wb_xbar_pkg::master_id_t g;
		logic                    drive;

		wb_rr_arbiter i_arb (
			.clk      (clk),
			.rstn     (rstn),
			.req_i    (t_req[t]),
			.gnt_o    (t_gnt[t]),
			.gnt_id_o (t_gnt_id[t])
		);

		// Grant lingers one cycle after release, so check the request too
		assign g     = t_gnt_id[t];
		assign drive = t_gnt[t] && t_req[t][g];

		assign t_cyc[t]   = drive && m_cyc[g];
		assign t_stb[t]   = drive && m_stb[g];
		assign t_we[t]    = drive && m_we[g];
		assign t_adr[t]   = drive ? m_adr[g] : '0;
		assign t_dat_w[t] = drive ? m_dat_w[g] : '0;
		assign t_sel[t]   = drive ? m_sel[g] : '0;
	end

	a_one_grant: assert property (
		@(posedge clk) disable iff (!rstn)
		!(t_gnt[0] && t_gnt[1] && t_gnt_id[0] == t_gnt_id[1])
	);

endmodule

`default_nettype wire

//--- verilog/wb_rr_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module wb_rr_arbiter (
	input  logic                    clk,
	input  logic                    rstn,
	input  logic [1:0]              req_i,
	output logic                    gnt_o,
	output wb_xbar_pkg::master_id_t gnt_id_o
);

	logic                    busy;
	wb_xbar_pkg::master_id_t last_id;
	logic [1:0]              above_last;
	logic [1:0]              masked_req;
	wb_xbar_pkg::master_id_t pick_id;

	// Requesters after the last winner get first pick
	assign above_last = (last_id == 1'b0) ? 2'b10 : 2'b00;
	assign masked_req = req_i & above_last;

	always_comb begin
		if (masked_req[1]) begin
			pick_id = 1'b1;
		end else if (req_i[0]) begin
			pick_id = 1'b0;
		end else begin
			pick_id = 1'b1;
		end
	end

	// last_id starts at 1 so master 0 wins the first tie
	always_ff @(posedge clk) begin
		if (!rstn) begin
			busy    <= 1'b0;
			last_id <= 1'b1;
		end else if (busy) begin
			// Hold while the winner keeps requesting
			if (!req_i[last_id]) begin
				busy <= 1'b0;
			end
		end else if (|req_i) begin
			busy    <= 1'b1;
			last_id <= pick_id;
		end
	end

	assign gnt_o    = busy;
	assign gnt_id_o = last_id;

	for (genvar i = 0; i < 2; i++) begin : g_chk
		a_gnt_had_req: assert property (
			@(posedge clk) disable iff (!rstn)
			($rose(gnt_o) && gnt_id_o == 1'(i)) |-> $past(req_i[i])
		);
	end

endmodule

`default_nettype wire

//--- verilog/wb_sram_target.sv
`include "wb_xbar_defines.svh"

`timescale 1ns/1ps
`default_nettype none

module wb_sram_target (
	input  logic     clk,
	input  logic     rstn,
	wb_bus_if.target bus
);

	wb_xbar_pkg::dat_t       mem [2**`WB_MEM_AW];
	wb_xbar_pkg::dat_t       rd_q;
	logic [`WB_MEM_AW-1:0]   word_idx;
	logic                    ack_q;
	logic                    hit;

	// Word address from byte address
	assign word_idx = bus.adr[`WB_MEM_AW+1:2];
	assign hit      = bus.cyc && bus.stb && !ack_q;

	always_ff @(posedge clk) begin
		if (!rstn) begin
			ack_q <= 1'b0;
			for (int i = 0; i < 2**`WB_MEM_AW; i++) begin
				mem[i] <= '0;
			end
		end else begin
			ack_q <= hit;
			if (hit && bus.we) begin
				for (int b = 0; b < `WB_SEL_W; b++) begin
					if (bus.sel[b]) begin
						mem[word_idx][8*b +: 8] <= bus.dat_w[8*b +: 8];
					end
				end
			end
		end
	end

	// Read word lands with the ack
	always_ff @(posedge clk) begin
		if (hit) begin
			rd_q <= mem[word_idx];
		end
	end

	assign bus.ack   = ack_q;
	assign bus.err   = 1'b0;
	assign bus.dat_r = rd_q;

	a_ack_pulse: assert property (
		@(posedge clk) disable iff (!rstn)
		ack_q |=> !ack_q
	);

endmodule

`default_nettype wire

//--- verilog/wb_subsys_top.sv
`timescale 1ns/1ps
`default_nettype none

module wb_subsys_top (
	input  logic              clk,
	input  logic              rstn,

	// Master 0
	input  logic              m0_cyc_i,
	input  logic              m0_stb_i,
	input  logic              m0_we_i,
	input  wb_xbar_pkg::adr_t m0_adr_i,
	input  wb_xbar_pkg::dat_t m0_dat_i,
	input  wb_xbar_pkg::sel_t m0_sel_i,
	output wb_xbar_pkg::dat_t m0_dat_o,
	output logic              m0_ack_o,
	output logic              m0_err_o,

	// Master 1
	input  logic              m1_cyc_i,
	input  logic              m1_stb_i,
	input  logic              m1_we_i,
	input  wb_xbar_pkg::adr_t m1_adr_i,
	input  wb_xbar_pkg::dat_t m1_dat_i,
	input  wb_xbar_pkg::sel_t m1_sel_i,
	output wb_xbar_pkg::dat_t m1_dat_o,
	output logic              m1_ack_o,
	output logic              m1_err_o,

	// Window configuration
	input  logic              cfg_we_i,
	input  logic              cfg_sel_i,
	input  wb_xbar_pkg::adr_t cfg_data_i
);

	wb_xbar_pkg::adr_t win_base;
	wb_xbar_pkg::adr_t win_limit;

	wb_bus_if m0_bus ();
	wb_bus_if m1_bus ();
	wb_bus_if mem_bus ();
	wb_bus_if err_bus ();

	assign m0_bus.cyc   = m0_cyc_i;
	assign m0_bus.stb   = m0_stb_i;
	assign m0_bus.we    = m0_we_i;
	assign m0_bus.adr   = m0_adr_i;
	assign m0_bus.dat_w = m0_dat_i;
	assign m0_bus.sel   = m0_sel_i;
	assign m0_dat_o     = m0_bus.dat_r;
	assign m0_ack_o     = m0_bus.ack;
	assign m0_err_o     = m0_bus.err;

	assign m1_bus.cyc   = m1_cyc_i;
	assign m1_bus.stb   = m1_stb_i;
	assign m1_bus.we    = m1_we_i;
	assign m1_bus.adr   = m1_adr_i;
	assign m1_bus.dat_w = m1_dat_i;
	assign m1_bus.sel   = m1_sel_i;
	assign m1_dat_o     = m1_bus.dat_r;
	assign m1_ack_o     = m1_bus.ack;
	assign m1_err_o     = m1_bus.err;

	wb_window_regs i_wb_window_regs (
		.clk         (clk),
		.rstn        (rstn),
		.cfg_we_i    (cfg_we_i),
		.cfg_sel_i   (cfg_sel_i),
		.cfg_data_i  (cfg_data_i),
		.win_base_o  (win_base),
		.win_limit_o (win_limit)
	);

	wb_interconnect_2x1 i_wb_interconnect_2x1 (
		.clk         (clk),
		.rstn        (rstn),
		.win_base_i  (win_base),
		.win_limit_i (win_limit),
		.m0          (m0_bus.target),
		.m1          (m1_bus.target),
		.mem         (mem_bus.initiator),
		.err         (err_bus.initiator)
	);

	wb_sram_target i_wb_sram_target (
		.clk  (clk),
		.rstn (rstn),
		.bus  (mem_bus.target)
	);

	wb_decode_err i_wb_decode_err (
		.clk  (clk),
		.rstn (rstn),
		.bus  (err_bus.target)
	);

endmodule

`default_nettype wire

//--- verilog/wb_window_regs.sv
`include "wb_xbar_defines.svh"

`timescale 1ns/1ps
`default_nettype none

module wb_window_regs (
	input  logic              clk,
	input  logic              rstn,
	input  logic              cfg_we_i,
	input  logic              cfg_sel_i,
	input  wb_xbar_pkg::adr_t cfg_data_i,
	output wb_xbar_pkg::adr_t win_base_o,
	output wb_xbar_pkg::adr_t win_limit_o
);

	wb_xbar_pkg::adr_t win_base_q;
	wb_xbar_pkg::adr_t win_limit_q;

	// Select 0 writes the base, 1 writes the limit
	always_ff @(posedge clk) begin
		if (!rstn) begin
			win_base_q  <= `WB_WIN_BASE_RST;
			win_limit_q <= `WB_WIN_LIMIT_RST;
		end else if (cfg_we_i) begin
			if (cfg_sel_i) begin
				win_limit_q <= cfg_data_i;
			end else begin
				win_base_q <= cfg_data_i;
			end
		end
	end

	// New values decode accesses from the next cycle on
	assign win_base_o  = win_base_q;
	assign win_limit_o = win_limit_q;

endmodule

`default_nettype wire

//--- verilog/wb_xbar_defines.svh
`default_nettype none

`ifndef WB_XBAR_DEFINES_SVH
`define WB_XBAR_DEFINES_SVH

// Bus widths
`define WB_ADR_W 32
`define WB_DAT_W 32
`define WB_SEL_W 4

// SRAM word address, 64 words
`define WB_MEM_AW 6

// Address window after reset, limit inclusive
`define WB_WIN_BASE_RST  32'h0000_1000
`define WB_WIN_LIMIT_RST 32'h0000_10FF

`endif

`default_nettype wire

//--- verilog/wb_xbar_pkg.sv
`include "wb_xbar_defines.svh"

`default_nettype none

package wb_xbar_pkg;

	typedef logic [`WB_ADR_W-1:0] adr_t;
	typedef logic [`WB_DAT_W-1:0] dat_t;
	typedef logic [`WB_SEL_W-1:0] sel_t;

	// One bit is enough for two masters
	typedef logic master_id_t;

	// Target captured for an access, TGT_NONE when idle
	typedef enum logic [1:0] {
		TGT_MEM  = 2'd0,
		TGT_ERR  = 2'd1,
		TGT_NONE = 2'd2
	} target_id_t;

endpackage

`default_nettype wire
